// File: gaDivPkg.sv
package gaDivPkg;

	// ==============================
	// widths
	// ==============================

	// operand width of the divider datapath
	localparam int DataWid = 28;
	// client tag, returned untouched with the result
	localparam int TagWid = 4;

	// ==============================
	// encodings
	// ==============================

	// sign mode of a request
	typedef enum logic [1:0] {
		opUnsigned         = 2'd0,
		opSigned           = 2'd1,
		opSignedByUnsigned = 2'd2
	} divOp_t;

	// serial divider sequence
	typedef enum logic [1:0] {
		stIdle = 2'd0,
		stDiv  = 2'd1,
		stDone = 2'd2
	} divState_t;

	// ==============================
	// transfer records
	// ==============================

	// one division request, 62 bits
	typedef struct packed {
		divOp_t              op;
		logic [DataWid-1:0]  dividend;
		logic [DataWid-1:0]  divisor;
		logic [TagWid-1:0]   tag;
	} divReq_t;

	// one division result, 61 bits
	typedef struct packed {
		logic [DataWid-1:0]  quotient;
		logic [DataWid-1:0]  remainder;
		logic                divByZero;
		logic [TagWid-1:0]   tag;
	} divRes_t;

endpackage

// File: gaDivider.sv
`timescale 1ns/1ps

module gaDivider
	import gaDivPkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  logic    start,
	input  divReq_t reqIn,
	output logic    idle,
	output logic    done,
	output divRes_t resOut
);

	// counter must hold DataWid
	localparam int CntWid = $clog2(DataWid + 1);

	// ==============================
	// state and working registers
	// ==============================

	divState_t          state;
	logic [CntWid-1:0]  cnt;

	// captured at start
	divOp_t             opReg;
	logic               qNeg;
	logic               rNeg;
	logic               dbz;
	logic [TagWid-1:0]  tagReg;

	// dividend shifts out the top while quotient bits shift in at the bottom
	logic [DataWid-1:0] quo;
	logic [DataWid-1:0] dvsr;
	logic [DataWid-1:0] rem;

	// one restoring step
	logic [DataWid:0]   remShift;
	logic               remGeq;
	logic [DataWid:0]   remNext;

	// operand conditioning on the request side
	logic               dvdNeg;
	logic               dvsNeg;
	logic [DataWid-1:0] dvdAbs;
	logic [DataWid-1:0] dvsAbs;

	// ==============================
	// operand conditioning
	// ==============================

	always_comb begin
		// dividend is signed in both signed modes
		dvdNeg = (reqIn.op != opUnsigned) && reqIn.dividend[DataWid-1];
		// divisor only counts as signed in opSigned
		dvsNeg = (reqIn.op == opSigned) && reqIn.divisor[DataWid-1];
		// minimum negative maps to 2^(DataWid-1), still a valid magnitude
		dvdAbs = dvdNeg ? -reqIn.dividend : reqIn.dividend;
		dvsAbs = dvsNeg ? -reqIn.divisor : reqIn.divisor;
	end

	// ==============================
	// shift and subtract
	// ==============================

	always_comb begin
		// bring down the next dividend bit
		remShift = {rem, quo[DataWid-1]};
		remGeq   = remShift >= {1'b0, dvsr};
		// restore by simply keeping the shifted value
		remNext  = remGeq ? remShift - {1'b0, dvsr} : remShift;
	end

	// ==============================
	// sequencer
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= stIdle;
			cnt   <= '0;
		end else begin
			case (state)
				stIdle: begin
					if (start) begin
						cnt   <= CntWid'(DataWid);
						state <= stDiv;
					end
				end
				stDiv: begin
					// last stDiv cycle only registers the result
					if (cnt != '0)
						cnt <= cnt - 1'b1;
					else
						state <= stDone;
				end
				stDone: state <= stIdle;
				default: state <= stIdle;
			endcase
		end
	end

	// datapath, loaded on start and stepped through stDiv
	always_ff @(posedge clk) begin
		if (state == stIdle && start) begin
			quo    <= dvdAbs;
			dvsr   <= dvsAbs;
			rem    <= '0;
			opReg  <= reqIn.op;
			// quotient negative when magnitudes came from opposite signs
			qNeg   <= dvdNeg ^ dvsNeg;
			// remainder follows the dividend
			rNeg   <= dvdNeg;
			dbz    <= reqIn.divisor == '0;
			tagReg <= reqIn.tag;
		end else if (state == stDiv) begin
			if (cnt != '0) begin
				quo <= {quo[DataWid-2:0], remGeq};
				// remNext is below dvsr here so the top bit is always clear
				rem <= remNext[DataWid-1:0];
			end else begin
				// apply the recorded signs, unsigned mode keeps magnitudes
				if (opReg != opUnsigned && qNeg)
					resOut.quotient <= -quo;
				else
					resOut.quotient <= quo;
				if (opReg != opUnsigned && rNeg)
					resOut.remainder <= -rem;
				else
					resOut.remainder <= rem;
				resOut.divByZero <= dbz;
				resOut.tag       <= tagReg;
			end
		end
	end

	// status straight from the state register
	assign idle = state == stIdle;
	assign done = state == stDone;

endmodule

// File: divPortQueue.sv
`timescale 1ns/1ps

module divPortQueue
	import gaDivPkg::*;
#(
	parameter int Depth = 4
) (
	input  logic    clk,
	input  logic    rst,
	input  logic    reqValid,
	input  divReq_t reqData,
	input  logic    pop,
	output logic    headValid,
	output divReq_t headData,
	output logic    creditReturn
);

	localparam int PtrWid = (Depth > 1) ? $clog2(Depth) : 1;
	// occupancy goes from 0 to Depth inclusive
	localparam int CntWid = $clog2(Depth + 1);

	// ==============================
	// storage
	// ==============================

	divReq_t           mem [Depth];
	logic [PtrWid-1:0] wrPtr;
	logic [PtrWid-1:0] rdPtr;
	logic [CntWid-1:0] count;

	// circular increment, Depth need not be a power of two
	function automatic logic [PtrWid-1:0] nextPtr(input logic [PtrWid-1:0] p);
		if (p == PtrWid'(Depth - 1))
			return '0;
		return p + 1'b1;
	endfunction

	// client holds a credit for every write, so a free slot always exists
	always_ff @(posedge clk) begin
		if (reqValid)
			mem[wrPtr] <= reqData;
	end

	// ==============================
	// pointers and occupancy
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			wrPtr        <= '0;
			rdPtr        <= '0;
			count        <= '0;
			creditReturn <= 1'b0;
		end else begin
			if (reqValid)
				wrPtr <= nextPtr(wrPtr);
			if (pop)
				rdPtr <= nextPtr(rdPtr);
			// simultaneous write and pop leaves the count unchanged
			case ({reqValid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// one credit back per entry sent toward the divider
			creditReturn <= pop;
		end
	end

	// head is visible as soon as it is written
	assign headValid = count != '0;
	assign headData  = mem[rdPtr];

endmodule

// File: divArbiter.sv
`timescale 1ns/1ps

module divArbiter
	import gaDivPkg::*;
#(
	parameter int NumPorts = 2
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic [NumPorts-1:0]     headValid,
	input  divReq_t [NumPorts-1:0]  headData,
	output logic [NumPorts-1:0]     pop,
	input  logic                    idle,
	input  logic                    done,
	input  divRes_t                 resIn,
	output logic                    start,
	output divReq_t                 reqOut,
	output logic [NumPorts-1:0]     resValid,
	output divRes_t                 resData
);

	localparam int IdxWid = (NumPorts > 1) ? $clog2(NumPorts) : 1;
	// one spare bit so rrPtr + i cannot wrap before the compare
	localparam int SumWid = IdxWid + 1;

	// port with highest priority next time
	logic [IdxWid-1:0] rrPtr;
	// port that issued the operation in the divider
	logic [IdxWid-1:0] owner;
	logic [IdxWid-1:0] grantIdx;
	logic              anyValid;

	// ==============================
	// round-robin search
	// ==============================

	always_comb begin
		logic [SumWid-1:0] cand;
		anyValid = 1'b0;
		grantIdx = rrPtr;
		cand     = '0;
		// scan from rrPtr upward, wrapping once
		for (int i = 0; i < NumPorts; i++) begin
			cand = {1'b0, rrPtr} + SumWid'(i);
			if (cand >= SumWid'(NumPorts))
				cand = cand - SumWid'(NumPorts);
			if (!anyValid && headValid[cand[IdxWid-1:0]]) begin
				anyValid = 1'b1;
				grantIdx = cand[IdxWid-1:0];
			end
		end
	end

	// only one operation in flight, so grant waits for idle
	assign start  = idle && anyValid;
	assign reqOut = headData[grantIdx];

	always_comb begin
		pop = '0;
		if (start)
			pop[grantIdx] = 1'b1;
	end

	// ==============================
	// owner and priority
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			rrPtr <= '0;
			owner <= '0;
		end else if (start) begin
			owner <= grantIdx;
			// granted port drops to lowest priority
			if (grantIdx == IdxWid'(NumPorts - 1))
				rrPtr <= '0;
			else
				rrPtr <= grantIdx + 1'b1;
		end
	end

	// ==============================
	// result steering
	// ==============================

	always_comb begin
		resValid = '0;
		if (done)
			resValid[owner] = 1'b1;
	end

	// shared result bus, only the owner's valid qualifies it
	assign resData = resIn;

endmodule

// File: gaDivUnit.sv
`timescale 1ns/1ps

module gaDivUnit
	import gaDivPkg::*;
#(
	parameter int Depth    = 4,
	parameter int NumPorts = 2
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic [NumPorts-1:0]     reqValid,
	input  divReq_t [NumPorts-1:0]  reqData,
	output logic [NumPorts-1:0]     creditReturn,
	output logic [NumPorts-1:0]     resValid,
	output divRes_t                 resData
);

	// ==============================
	// internal wiring
	// ==============================

	// queue heads toward the arbiter
	logic [NumPorts-1:0]    headValid;
	divReq_t [NumPorts-1:0] headData;
	logic [NumPorts-1:0]    pop;

	// arbiter to divider
	logic    divStart;
	logic    divIdle;
	logic    divDone;
	divReq_t divReq;
	divRes_t divRes;

	// ==============================
	// per-port request queues
	// ==============================

	for (genvar p = 0; p < NumPorts; p++) begin : gPort
		divPortQueue #(
			.Depth(Depth)
		) uQueue (
			.clk         (clk),
			.rst         (rst),
			.reqValid    (reqValid[p]),
			.reqData     (reqData[p]),
			.pop         (pop[p]),
			.headValid   (headValid[p]),
			.headData    (headData[p]),
			.creditReturn(creditReturn[p])
		);
	end

	// ==============================
	// arbitration and return path
	// ==============================

	divArbiter #(
		.NumPorts(NumPorts)
	) uArb (
		.clk      (clk),
		.rst      (rst),
		.headValid(headValid),
		.headData (headData),
		.pop      (pop),
		.idle     (divIdle),
		.done     (divDone),
		.resIn    (divRes),
		.start    (divStart),
		.reqOut   (divReq),
		.resValid (resValid),
		.resData  (resData)
	);

	// single shared serial divider
	gaDivider uDiv (
		.clk   (clk),
		.rst   (rst),
		.start (divStart),
		.reqIn (divReq),
		.idle  (divIdle),
		.done  (divDone),
		.resOut(divRes)
	);

endmodule

// File: gaDivUnit_asserts.sv
`timescale 1ns/1ps

module gaDivUnit_asserts
	import gaDivPkg::*;
#(
	parameter int NumPorts = 2
) (
	input logic                   clk,
	input logic                   rst,
	input logic [NumPorts-1:0]    reqValid,
	input divReq_t [NumPorts-1:0] reqData,
	input logic [NumPorts-1:0]    resValid,
	input divRes_t                resData,
	input logic [NumPorts-1:0]    headValid,
	input logic [NumPorts-1:0]    pop,
	input logic                   divStart
);

	localparam int IdxWid = (NumPorts > 1) ? $clog2(NumPorts) : 1;

	// read by the testbench for its closing line
	int failCount = 0;
	// port that won the previous grant
	logic [IdxWid-1:0] lastGrant;

	// ==============================
	// reference model
	// ==============================

	// widen to 64 bits, the sign of each operand follows the mode
	function automatic divRes_t expectResult(input divReq_t r);
		longint  a;
		longint  b;
		longint  q;
		longint  m;
		divRes_t e;
		e = '0;
		if (r.op == opUnsigned)
			a = longint'(r.dividend);
		else
			a = longint'($signed(r.dividend));
		// divisor is signed in opSigned only
		if (r.op == opSigned)
			b = longint'($signed(r.divisor));
		else
			b = longint'(r.divisor);
		e.tag       = r.tag;
		e.divByZero = r.divisor == '0;
		if (b != 0) begin
			// truncating division, remainder keeps the dividend's sign
			q           = a / b;
			m           = a % b;
			e.quotient  = q[DataWid-1:0];
			e.remainder = m[DataWid-1:0];
		end
		return e;
	endfunction

	// ==============================
	// per-port order and value
	// ==============================

	for (genvar p = 0; p < NumPorts; p++) begin : gPort
		divReq_t accepted [$];
		// registered front of the model queue
		divRes_t expRes;
		logic    hasPending;

		always @(posedge clk) begin
			if (rst) begin
				accepted.delete();
			end else begin
				if (resValid[p] && accepted.size() > 0)
					void'(accepted.pop_front());
				if (reqValid[p])
					accepted.push_back(reqData[p]);
			end
			hasPending <= accepted.size() != 0;
			expRes     <= (accepted.size() != 0) ? expectResult(accepted[0]) : '0;
		end

		aPending: assert property (@(posedge clk) disable iff (rst)
			resValid[p] |-> hasPending)
			else begin
				failCount++;
				$error("port %0d returned a result with no request pending", p);
			end

		aTag: assert property (@(posedge clk) disable iff (rst)
			resValid[p] && hasPending |-> resData.tag == expRes.tag)
			else begin
				failCount++;
				$error("Error at %0t: port %0d tag got %h expected %h", $time, p,
					$sampled(resData.tag), $sampled(expRes.tag));
			end

		aDbz: assert property (@(posedge clk) disable iff (rst)
			resValid[p] && hasPending |-> resData.divByZero == expRes.divByZero)
			else begin
				failCount++;
				$error("Error at %0t: port %0d divByZero got %b expected %b", $time, p,
					$sampled(resData.divByZero), $sampled(expRes.divByZero));
			end

		// quotient and remainder are unspecified on a zero divisor
		aQuot: assert property (@(posedge clk) disable iff (rst)
			resValid[p] && hasPending && !expRes.divByZero |->
			resData.quotient == expRes.quotient)
			else begin
				failCount++;
				$error("Error at %0t: port %0d quotient got %h expected %h", $time, p,
					$sampled(resData.quotient), $sampled(expRes.quotient));
			end

		aRem: assert property (@(posedge clk) disable iff (rst)
			resValid[p] && hasPending && !expRes.divByZero |->
			resData.remainder == expRes.remainder)
			else begin
				failCount++;
				$error("Error at %0t: port %0d remainder got %h expected %h", $time, p,
					$sampled(resData.remainder), $sampled(expRes.remainder));
			end
	end

	// ==============================
	// arbitration
	// ==============================

	always @(posedge clk) begin
		if (rst) begin
			// port 0 wins the first contest
			lastGrant <= IdxWid'(NumPorts - 1);
		end else if (divStart) begin
			for (int i = 0; i < NumPorts; i++)
				if (pop[i])
					lastGrant <= IdxWid'(i);
		end
	end

	aOneRes: assert property (@(posedge clk) disable iff (rst) $onehot0(resValid))
		else begin
			failCount++;
			$error("results were offered on more than one port in the same cycle");
		end

	// result comes back a fixed time after the start edge
	aLatency: assert property (@(posedge clk) disable iff (rst)
		divStart |-> ##(DataWid + 2) $onehot(resValid))
		else begin
			failCount++;
			$error("no result was offered %0d cycles after the divider started",
				DataWid + 2);
		end

	// with contention the previous winner must step aside
	aFair: assert property (@(posedge clk) disable iff (rst)
		divStart && $countones(headValid) > 1 |-> !pop[lastGrant])
		else begin
			failCount++;
			$error("round-robin violated, port %0d granted twice in a row", $sampled(lastGrant));
		end

endmodule

// File: gaDivUnit_tb.sv
`timescale 1ns/1ps

module gaDivUnit_tb
	import gaDivPkg::*;
();

	localparam int Depth    = 4;
	localparam int NumPorts = 2;
	// requests sent on each port
	localparam int NumReqs  = 60;
	// each operation costs at most DataWid+4 cycles of 100 ns
	localparam longint WatchdogNs = longint'(NumReqs) * (DataWid + 4) * NumPorts * 100 + 50000;
	// enough to empty every queue twice over
	localparam int DrainCycles = 2 * NumPorts * Depth * (DataWid + 4);

	logic                   clk;
	logic                   rst;
	logic [NumPorts-1:0]    reqValid;
	divReq_t [NumPorts-1:0] reqData;
	logic [NumPorts-1:0]    creditReturn;
	logic [NumPorts-1:0]    resValid;
	divRes_t                resData;

	// client side bookkeeping
	int credits [NumPorts];
	int sent [NumPorts];
	int received [NumPorts];
	int tbErrors;

	gaDivUnit #(
		.Depth   (Depth),
		.NumPorts(NumPorts)
	) dut (
		.clk         (clk),
		.rst         (rst),
		.reqValid    (reqValid),
		.reqData     (reqData),
		.creditReturn(creditReturn),
		.resValid    (resValid),
		.resData     (resData)
	);

	// checker sees the internal grant path too
	bind gaDivUnit gaDivUnit_asserts #(
		.NumPorts(NumPorts)
	) chk (
		.clk      (clk),
		.rst      (rst),
		.reqValid (reqValid),
		.reqData  (reqData),
		.resValid (resValid),
		.resData  (resData),
		.headValid(headValid),
		.pop      (pop),
		.divStart (divStart)
	);

	// 100 ns period
	always #50 clk = ~clk;

	// ==============================
	// stimulus helpers
	// ==============================

	// random request with a share of edge cases
	function automatic divReq_t buildRequest(input int idx);
		divReq_t r;
		int      kind;
		r.op       = divOp_t'($urandom_range(2, 0));
		r.tag      = TagWid'(idx);
		r.dividend = DataWid'($urandom);
		r.divisor  = DataWid'($urandom);
		kind       = $urandom_range(7, 0);
		case (kind)
			0: r.divisor = '0;
			// minimum negative dividend
			1: r.dividend = {1'b1, {(DataWid - 1){1'b0}}};
			2: r.divisor = DataWid'(1);
			3: begin
				// dividend below divisor, quotient zero
				r.divisor  = r.divisor | DataWid'(1);
				r.dividend = r.dividend % r.divisor;
			end
			// all ones, -1 when signed
			4: r.divisor = '1;
			5: begin
				r.dividend = {1'b1, {(DataWid - 1){1'b0}}};
				r.divisor  = '1;
			end
			// short divisor gives a wide quotient
			6: r.divisor = r.divisor >> $urandom_range(DataWid - 1, 8);
			default: ;
		endcase
		return r;
	endfunction

	function automatic bit allRequestsSent();
		for (int p = 0; p < NumPorts; p++)
			if (sent[p] < NumReqs)
				return 1'b0;
		return 1'b1;
	endfunction

	function automatic bit allResultsBack();
		for (int p = 0; p < NumPorts; p++)
			if (received[p] != sent[p])
				return 1'b0;
		return 1'b1;
	endfunction

	// wait for outstanding results, bounded
	task automatic drainResults();
		int cycles;
		cycles = 0;
		while (!allResultsBack() && cycles < DrainCycles) begin
			@(posedge clk);
			cycles++;
		end
		for (int p = 0; p < NumPorts; p++) begin
			if (received[p] != sent[p]) begin
				tbErrors++;
				$display("port %0d got only %0d of %0d results back", p, received[p], sent[p]);
			end
			if (credits[p] != Depth) begin
				tbErrors++;
				$display("port %0d holds %0d credits after draining, should hold %0d",
					p, credits[p], Depth);
			end
		end
	endtask

	// ==============================
	// credit and result counting
	// ==============================

	// falling edge, outputs are settled
	always @(negedge clk) begin
		if (!rst) begin
			for (int p = 0; p < NumPorts; p++) begin
				if (creditReturn[p]) begin
					credits[p]++;
					if (credits[p] > Depth) begin
						tbErrors++;
						$display("port %0d was given more credits than the queue depth", p);
					end
				end
				if (resValid[p])
					received[p]++;
			end
		end
	end

	// ==============================
	// main sequence
	// ==============================

	initial begin
		void'($urandom(32'h9e33_4d49));
		clk       = 1'b0;
		rst       = 1'b1;
		reqValid  = '0;
		reqData   = '0;
		tbErrors  = 0;
		for (int p = 0; p < NumPorts; p++) begin
			credits[p]  = Depth;
			sent[p]     = 0;
			received[p] = 0;
		end
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		// three of four cycles busy keeps both queues contending
		while (!allRequestsSent()) begin
			@(posedge clk);
			for (int p = 0; p < NumPorts; p++) begin
				if (credits[p] > 0 && sent[p] < NumReqs && $urandom_range(3, 0) != 0) begin
					reqValid[p] <= 1'b1;
					reqData[p]  <= buildRequest(sent[p]);
					credits[p]--;
					sent[p]++;
				end else begin
					reqValid[p] <= 1'b0;
				end
			end
		end
		@(posedge clk);
		reqValid <= '0;
		drainResults();
		$display("errors: testbench %0d, assertions %0d", tbErrors, dut.chk.failCount);
		if (tbErrors == 0 && dut.chk.failCount == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(WatchdogNs);
		$display("watchdog expired after %0d ns, the run did not complete", WatchdogNs);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// File: src.f
gaDivPkg.sv
gaDivider.sv
divPortQueue.sv
divArbiter.sv
gaDivUnit.sv
gaDivUnit_asserts.sv
gaDivUnit_tb.sv

// File: run.sh
#!/bin/sh
# build and run the divide unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f \
	--top-module gaDivUnit_tb -o simv &&
	./obj_dir/simv +verilator+error+limit+1000 > sim.log 2>&1 ||
	echo "build or simulation ended with an error"
cat sim.log 2>/dev/null
grep -q "Simulation finished: PASS" sim.log && echo "run passed" && exit 0 ||
	{ echo "run failed"; exit 1; }
